/* design/prng_settings.svh */
// Build-time sizes and register offsets of the PRNG, included by every file that needs them
`ifndef PRNG_SETTINGS_SVH
`define PRNG_SETTINGS_SVH

// Lane shape
`define PRNG_LANE_WIDTH 16
`define PRNG_NUM_LANES 4

// Word FIFO and packing
`define PRNG_FIFO_DEPTH 4
`define PRNG_STEPS_PER_WORD 8

// AXI4-Lite bus widths
`define PRNG_AXI_ADDR_WIDTH 8
`define PRNG_AXI_DATA_WIDTH 32

// Register map byte offsets
`define PRNG_REG_CTRL 8'h00
`define PRNG_REG_STATUS 8'h04
`define PRNG_REG_DATA 8'h08
`define PRNG_REG_SEED_BASE 8'h10
`define PRNG_REG_TAPS_BASE 8'h20

`endif

/* design/prng_pkg.sv */
// Shared types of the PRNG design, imported by the modules that use them
`include "prng_settings.svh"

package prng_pkg;

    // One lane state, also used for seeds and tap masks
    typedef logic [`PRNG_LANE_WIDTH-1:0] lane_state_t;

    // AXI4-Lite payload types
    typedef logic [`PRNG_AXI_DATA_WIDTH-1:0] bus_word_t;
    typedef logic [`PRNG_AXI_ADDR_WIDTH-1:0] bus_addr_t;
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t resp_okay = 2'b00;
    localparam axi_resp_t resp_slverr = 2'b10;

    // Channel FSM of the register block
    typedef enum logic {st_idle, st_resp} axi_state_t;

endpackage

/* design/prng_axil_regs.sv */
// AXI4-Lite slave with control, seed and tap registers that also pops the word FIFO on DATA reads
`timescale 1ns/1ns
`include "prng_settings.svh"

module prng_axil_regs
    import prng_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  bus_addr_t   awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  bus_word_t   wdata,
    input  logic        wvalid,
    output logic        wready,
    output axi_resp_t   bresp,
    output logic        bvalid,
    input  logic        bready,
    input  bus_addr_t   araddr,
    input  logic        arvalid,
    output logic        arready,
    output bus_word_t   rdata,
    output axi_resp_t   rresp,
    output logic        rvalid,
    input  logic        rready,
    output lane_state_t seeds [`PRNG_NUM_LANES],
    output lane_state_t taps [`PRNG_NUM_LANES],
    output logic        run,
    output logic        load,
    output logic        pop,
    input  bus_word_t   fifo_data,
    input  logic [$clog2(`PRNG_FIFO_DEPTH+1)-1:0] fifo_count
);

    axi_state_t wr_state;
    axi_state_t rd_state;
    logic       wr_ok;
    logic       rd_ok;
    bus_word_t  rd_mux;

    // ------------------------------------------------------------------------
    // Write channel
    // ------------------------------------------------------------------------
    // Address and data are taken together in one cycle
    assign awready = (wr_state == st_idle) && awvalid && wvalid;
    assign wready = awready;
    assign bvalid = (wr_state == st_resp);

    // Only CTRL and the per-lane seed and tap words accept writes
    always_comb begin
        wr_ok = (awaddr == `PRNG_REG_CTRL);
        for (int i = 0; i < `PRNG_NUM_LANES; i++) begin
            if (awaddr == bus_addr_t'(`PRNG_REG_SEED_BASE + 4 * i) ||
                awaddr == bus_addr_t'(`PRNG_REG_TAPS_BASE + 4 * i)) begin
                wr_ok = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= st_idle;
        end else if (awready) begin
            wr_state <= st_resp;
        end else if (bvalid && bready) begin
            wr_state <= st_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (awready) begin
            bresp <= wr_ok ? resp_okay : resp_slverr;
        end
    end

    // Register file updates on the write handshake edge
    // Load is a single-cycle pulse in the cycle after the write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
            load <= 1'b0;
            seeds <= '{default: '0};
            taps <= '{default: '0};
        end else begin
            load <= 1'b0;
            if (awready) begin
                if (awaddr == `PRNG_REG_CTRL) begin
                    run <= wdata[0];
                    load <= wdata[1];
                end
                for (int i = 0; i < `PRNG_NUM_LANES; i++) begin
                    if (awaddr == bus_addr_t'(`PRNG_REG_SEED_BASE + 4 * i))
                        seeds[i] <= wdata[$bits(lane_state_t)-1:0];
                    if (awaddr == bus_addr_t'(`PRNG_REG_TAPS_BASE + 4 * i))
                        taps[i] <= wdata[$bits(lane_state_t)-1:0];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read channel
    // ------------------------------------------------------------------------
    assign arready = (rd_state == st_idle) && arvalid;
    assign rvalid = (rd_state == st_resp);

    // Empty FIFO reads and unmapped offsets give zero with SLVERR
    always_comb begin
        rd_mux = '0;
        rd_ok = 1'b1;
        case (araddr)
            `PRNG_REG_CTRL:   rd_mux = bus_word_t'(run);
            `PRNG_REG_STATUS: rd_mux = bus_word_t'(fifo_count);
            `PRNG_REG_DATA: begin
                rd_ok = (fifo_count != '0);
                if (rd_ok)
                    rd_mux = fifo_data;
            end
            default: begin
                rd_ok = 1'b0;
                for (int i = 0; i < `PRNG_NUM_LANES; i++) begin
                    if (araddr == bus_addr_t'(`PRNG_REG_SEED_BASE + 4 * i)) begin
                        rd_mux = bus_word_t'(seeds[i]);
                        rd_ok = 1'b1;
                    end
                    if (araddr == bus_addr_t'(`PRNG_REG_TAPS_BASE + 4 * i)) begin
                        rd_mux = bus_word_t'(taps[i]);
                        rd_ok = 1'b1;
                    end
                end
            end
        endcase
    end

    // Head word leaves the FIFO on the same edge it is captured
    assign pop = arready && (araddr == `PRNG_REG_DATA) && (fifo_count != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= st_idle;
        end else if (arready) begin
            rd_state <= st_resp;
        end else if (rvalid && rready) begin
            rd_state <= st_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (arready) begin
            rdata <= rd_mux;
            rresp <= rd_ok ? resp_okay : resp_slverr;
        end
    end

endmodule

/* design/prng_lane.sv */
// One Fibonacci shift register lane with an add-one step, instantiated per lane at the top level
`timescale 1ns/1ns

module prng_lane
    import prng_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        step,
    input  logic        load,
    input  lane_state_t seed,
    input  lane_state_t taps,
    output logic        serial
);

    localparam int lane_w = $bits(lane_state_t);

    lane_state_t         state_q;
    lane_state_t         shifted;
    lane_state_t         stepped;
    logic                feedback;
    logic [lane_w:0]     borrow;

    // Parity of the tapped bits enters at the top
    assign feedback = ^(state_q & taps);
    assign shifted = {feedback, state_q[lane_w-1:1]};

    // Subtract all ones through a borrow chain
    // which equals adding one modulo 2^lane_w
    assign borrow[0] = 1'b0;
    for (genvar b = 0; b < lane_w; b++) begin : gen_borrow
        assign stepped[b] = ~(shifted[b] ^ borrow[b]);
        assign borrow[b+1] = ~shifted[b] | borrow[b];
    end

    // Load takes priority over step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= '0;
        end else if (load) begin
            state_q <= seed;
        end else if (step) begin
            state_q <= stepped;
        end
    end

    // Bit shifted out by the next step
    assign serial = state_q[0];

endmodule

/* design/prng_word_packer.sv */
// Packs lane serial bits into 32-bit words, queues them in a FIFO and throttles lane stepping
`timescale 1ns/1ns
`include "prng_settings.svh"

module prng_word_packer
    import prng_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    input  logic                          load,
    input  logic [`PRNG_NUM_LANES-1:0]    serials,
    output logic                          step,
    input  logic                          pop,
    output bus_word_t                     fifo_data,
    output logic [$clog2(`PRNG_FIFO_DEPTH+1)-1:0] fifo_count
);

    localparam int idx_w = $clog2(`PRNG_STEPS_PER_WORD);
    localparam int ptr_w = $clog2(`PRNG_FIFO_DEPTH);

    logic [idx_w-1:0] step_idx;
    bus_word_t        gather_q;
    bus_word_t        word_next;
    logic             last_step;
    logic             full;
    logic             push;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    bus_word_t        mem [`PRNG_FIFO_DEPTH];

    // ------------------------------------------------------------------------
    // Step control
    // ------------------------------------------------------------------------
    assign last_step = (step_idx == idx_w'(`PRNG_STEPS_PER_WORD - 1));
    assign full = (fifo_count == $bits(fifo_count)'(`PRNG_FIFO_DEPTH));

    // Only the word-completing step has to wait for FIFO space
    assign step = run && !load && (!full || !last_step);
    assign push = step && last_step;

    // Lane i of step k lands in word bit k*lanes+i
    always_comb begin
        word_next = gather_q;
        word_next[step_idx * `PRNG_NUM_LANES +: `PRNG_NUM_LANES] = serials;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_idx <= '0;
            gather_q <= '0;
        end else if (load) begin
            step_idx <= '0;
            gather_q <= '0;
        end else if (step) begin
            step_idx <= last_step ? '0 : step_idx + 1'b1;
            gather_q <= last_step ? '0 : word_next;
        end
    end

    // ------------------------------------------------------------------------
    // Word FIFO
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_count <= '0;
        end else if (load) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_count <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            // Simultaneous push and pop leave the count unchanged
            if (push && !pop)
                fifo_count <= fifo_count + 1'b1;
            else if (pop && !push)
                fifo_count <= fifo_count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= word_next;
    end

    assign fifo_data = mem[rd_ptr];

endmodule

/* design/prng_top.sv */
// Top level of the four-lane PRNG with its AXI4-Lite control port
`timescale 1ns/1ns
`include "prng_settings.svh"

module prng_top
    import prng_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // AXI4-Lite write address and data
    input  bus_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  bus_word_t wdata,
    input  logic      wvalid,
    output logic      wready,
    // Write response
    output axi_resp_t bresp,
    output logic      bvalid,
    input  logic      bready,
    // Read address and data
    input  bus_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    output bus_word_t rdata,
    output axi_resp_t rresp,
    output logic      rvalid,
    input  logic      rready
);

    lane_state_t                  seeds [`PRNG_NUM_LANES];
    lane_state_t                  taps [`PRNG_NUM_LANES];
    logic                         run;
    logic                         load;
    logic                         pop;
    logic                         step;
    logic [`PRNG_NUM_LANES-1:0]   serials;
    bus_word_t                    fifo_data;
    logic [$clog2(`PRNG_FIFO_DEPTH+1)-1:0] fifo_count;

    // ------------------------------------------------------------------------
    // Control registers
    // ------------------------------------------------------------------------
    prng_axil_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .seeds      (seeds),
        .taps       (taps),
        .run        (run),
        .load       (load),
        .pop        (pop),
        .fifo_data  (fifo_data),
        .fifo_count (fifo_count)
    );

    // All lanes share step and load so they advance in lockstep
    for (genvar i = 0; i < `PRNG_NUM_LANES; i++) begin : gen_lane
        prng_lane u_lane (
            .clk    (clk),
            .rst_n  (rst_n),
            .step   (step),
            .load   (load),
            .seed   (seeds[i]),
            .taps   (taps[i]),
            .serial (serials[i])
        );
    end

    // Packer drives step back to the lanes
    prng_word_packer u_packer (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .load       (load),
        .serials    (serials),
        .step       (step),
        .pop        (pop),
        .fifo_data  (fifo_data),
        .fifo_count (fifo_count)
    );

endmodule

/* testbench/tb_clock_gen.sv */
// Free-running clock source for the testbench, instantiated once by the testbench top
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period_ns = 40
) (
    output logic clk
);

    // Starts low, first rising edge after half a period
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

/* testbench/tb_prng_top.sv */
// Self-checking testbench that drives the PRNG over AXI4-Lite and checks words against a model
`timescale 1ns/1ns
`include "prng_settings.svh"

module tb_prng_top
    import prng_pkg::*;
();

    localparam int cycle_limit = 4000;
    localparam int wait_limit = 50;
    // Fixed feedback masks, one per lane
    localparam lane_state_t lane_taps [`PRNG_NUM_LANES] = '{
        16'hB400, 16'hD008, 16'hA801, 16'h9C00
    };

    logic        clk;
    logic        rst_n;
    bus_addr_t   awaddr;
    logic        awvalid;
    logic        awready;
    bus_word_t   wdata;
    logic        wvalid;
    logic        wready;
    axi_resp_t   bresp;
    logic        bvalid;
    logic        bready;
    bus_addr_t   araddr;
    logic        arvalid;
    logic        arready;
    bus_word_t   rdata;
    axi_resp_t   rresp;
    logic        rvalid;
    logic        rready;

    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int          stall_cycles = 0;
    int          ready_delay = 0;
    string       waiting_for = "";
    lane_state_t seed_val [`PRNG_NUM_LANES];
    lane_state_t tap_val [`PRNG_NUM_LANES];
    lane_state_t model_state [`PRNG_NUM_LANES];
    bus_word_t   rd_word;
    axi_resp_t   rd_resp;

    tb_clock_gen #(.period_ns(40)) u_clock_gen (.clk(clk));

    prng_top u_prng_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    // ------------------------------------------------------------------------
    // Checking helpers
    // ------------------------------------------------------------------------
    task automatic note_error(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic expect_value(input bus_word_t got, input bus_word_t exp, input string what);
        checks++;
        assert (got == exp)
        else note_error($sformatf("%s: got %08h, expected %08h", what, got, exp));
    endtask

    // Responses must hold steady while the master stalls
    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
    else note_error("bvalid or bresp changed before bready");

    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else note_error("rvalid or read payload changed before rready");

    // Watchdog for stuck handshakes and for the whole run
    always @(posedge clk) begin
        cycle_count++;
        if (stall_cycles >= wait_limit) begin
            $display("Timed out waiting for %s", waiting_for);
            $display("Errors found");
            $finish;
        end else if (cycle_count >= cycle_limit) begin
            $display("Run stopped at the limit of %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    // Shift right, parity of tapped bits on top, then add one
    function automatic lane_state_t lane_advance(input lane_state_t s, input lane_state_t t);
        lane_state_t shifted;
        shifted = {^(s & t), s[`PRNG_LANE_WIDTH-1:1]};
        return shifted + 1'b1;
    endfunction

    // Step k of lane i lands in bit 4k+i
    function automatic bus_word_t model_next_word();
        bus_word_t w;
        w = '0;
        for (int k = 0; k < `PRNG_STEPS_PER_WORD; k++) begin
            for (int i = 0; i < `PRNG_NUM_LANES; i++) begin
                w[k * `PRNG_NUM_LANES + i] = model_state[i][0];
                model_state[i] = lane_advance(model_state[i], tap_val[i]);
            end
        end
        return w;
    endfunction

    // ------------------------------------------------------------------------
    // AXI4-Lite master tasks
    // ------------------------------------------------------------------------
    // Drive 2 ns after the edge, sample on the falling edge
    task automatic axi_write(input bus_addr_t addr, input bus_word_t data,
                             output axi_resp_t resp);
        @(posedge clk);
        #2;
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        waiting_for = "awready and wready";
        do begin
            @(negedge clk);
            stall_cycles++;
        end while (!(awready && wready));
        stall_cycles = 0;
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid = 1'b0;
        // Optional stall on the response channel
        repeat (ready_delay) begin
            @(posedge clk);
            #2;
        end
        bready = 1'b1;
        waiting_for = "bvalid";
        do begin
            @(negedge clk);
            stall_cycles++;
        end while (!bvalid);
        stall_cycles = 0;
        resp = bresp;
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axi_read(input bus_addr_t addr, output bus_word_t data,
                            output axi_resp_t resp);
        @(posedge clk);
        #2;
        araddr = addr;
        arvalid = 1'b1;
        waiting_for = "arready";
        do begin
            @(negedge clk);
            stall_cycles++;
        end while (!arready);
        stall_cycles = 0;
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        repeat (ready_delay) begin
            @(posedge clk);
            #2;
        end
        rready = 1'b1;
        waiting_for = "rvalid";
        do begin
            @(negedge clk);
            stall_cycles++;
        end while (!rvalid);
        stall_cycles = 0;
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic write_expect(input bus_addr_t addr, input bus_word_t data,
                                input axi_resp_t exp_resp, input string what);
        axi_resp_t resp;
        axi_write(addr, data, resp);
        expect_value(bus_word_t'(resp), bus_word_t'(exp_resp), {what, " bresp"});
    endtask

    task automatic read_expect(input bus_addr_t addr, input bus_word_t exp_data,
                               input axi_resp_t exp_resp, input string what);
        bus_word_t data;
        axi_resp_t resp;
        axi_read(addr, data, resp);
        expect_value(data, exp_data, {what, " rdata"});
        expect_value(bus_word_t'(resp), bus_word_t'(exp_resp), {what, " rresp"});
    endtask

    // Poll STATUS until the FIFO holds at least n words
    task automatic wait_for_count(input int n);
        bus_word_t data;
        axi_resp_t resp;
        do begin
            axi_read(`PRNG_REG_STATUS, data, resp);
        end while (int'(data) < n);
    endtask

    task automatic pop_and_check(input string what);
        wait_for_count(1);
        read_expect(`PRNG_REG_DATA, model_next_word(), resp_okay, what);
    endtask

    task automatic write_seeds();
        for (int i = 0; i < `PRNG_NUM_LANES; i++) begin
            seed_val[i] = lane_state_t'($urandom);
            write_expect(bus_addr_t'(`PRNG_REG_SEED_BASE + 4 * i), bus_word_t'(seed_val[i]),
                         resp_okay, $sformatf("SEED %0d write", i));
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        rst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        void'($urandom(83));
        tap_val = lane_taps;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Idle bus after reset, empty FIFO
        @(negedge clk);
        expect_value(bus_word_t'({awready, wready, bvalid, arready, rvalid}), '0,
                     "handshake outputs after reset");
        read_expect(`PRNG_REG_STATUS, '0, resp_okay, "STATUS after reset");
        read_expect(`PRNG_REG_DATA, '0, resp_slverr, "DATA read with empty FIFO");

        // Register readback with stalled response channels
        ready_delay = 3;
        write_seeds();
        for (int i = 0; i < `PRNG_NUM_LANES; i++) begin
            write_expect(bus_addr_t'(`PRNG_REG_TAPS_BASE + 4 * i), bus_word_t'(tap_val[i]),
                         resp_okay, $sformatf("TAPS %0d write", i));
            read_expect(bus_addr_t'(`PRNG_REG_SEED_BASE + 4 * i), bus_word_t'(seed_val[i]),
                        resp_okay, $sformatf("SEED %0d readback", i));
            read_expect(bus_addr_t'(`PRNG_REG_TAPS_BASE + 4 * i), bus_word_t'(tap_val[i]),
                        resp_okay, $sformatf("TAPS %0d readback", i));
        end
        ready_delay = 0;
        write_expect(`PRNG_REG_CTRL, 32'h3, resp_okay, "CTRL run and load");
        read_expect(`PRNG_REG_CTRL, 32'h1, resp_okay, "CTRL readback with run set");
        write_expect(`PRNG_REG_CTRL, 32'h0, resp_okay, "CTRL clear");
        read_expect(`PRNG_REG_CTRL, 32'h0, resp_okay, "CTRL readback cleared");
        write_expect(`PRNG_REG_STATUS, 32'h5, resp_slverr, "STATUS write");
        write_expect(8'h30, 32'h1234, resp_slverr, "unmapped write");
        read_expect(8'h30, '0, resp_slverr, "unmapped read");

        // Load seeds and run, words follow the model
        model_state = seed_val;
        write_expect(`PRNG_REG_CTRL, 32'h3, resp_okay, "CTRL load and run");
        repeat (3) pop_and_check("word after load");

        // FIFO fills and holds, then drains without a lost step
        wait_for_count(`PRNG_FIFO_DEPTH);
        repeat (5 * `PRNG_STEPS_PER_WORD) @(posedge clk);
        read_expect(`PRNG_REG_STATUS, `PRNG_FIFO_DEPTH, resp_okay, "STATUS holding at full");
        repeat (6) pop_and_check("word after full FIFO");

        // Stopping freezes the FIFO, restarting continues the sequence
        write_expect(`PRNG_REG_CTRL, 32'h0, resp_okay, "CTRL stop");
        // Drain the words queued before the stop
        axi_read(`PRNG_REG_STATUS, rd_word, rd_resp);
        while (rd_word != '0) begin
            read_expect(`PRNG_REG_DATA, model_next_word(), resp_okay,
                        "word queued before stop");
            axi_read(`PRNG_REG_STATUS, rd_word, rd_resp);
        end
        repeat (5 * `PRNG_STEPS_PER_WORD) @(posedge clk);
        read_expect(`PRNG_REG_STATUS, '0, resp_okay, "STATUS while stopped");
        write_expect(`PRNG_REG_CTRL, 32'h1, resp_okay, "CTRL restart");
        repeat (4) pop_and_check("word after restart");

        // Reload while running from fresh seeds
        write_seeds();
        model_state = seed_val;
        write_expect(`PRNG_REG_CTRL, 32'h3, resp_okay, "CTRL reload while running");
        read_expect(`PRNG_REG_STATUS, '0, resp_okay, "STATUS right after reload");
        repeat (3) pop_and_check("word after reload");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+design
design/prng_pkg.sv
design/prng_axil_regs.sv
design/prng_lane.sv
design/prng_word_packer.sv
design/prng_top.sv
testbench/tb_clock_gen.sv
testbench/tb_prng_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the PRNG testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_prng_top -o sim_prng
./obj_dir/sim_prng | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
